// File: Makefile
TB_TOP  = fp_add_sub_tb
RTL_TOP = fp_add_sub

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f build.f --top-module $(RTL_TOP)

sim:
	verilator --binary --timing -Wno-fatal -f build.f --top-module $(TB_TOP)
	@result="$$(./obj_dir/V$(TB_TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -q "^Simulation passed$$"

clean:
	rm -rf obj_dir

// File: build.f
+incdir+.
fp_pkg.sv
pipe_delay.sv
fp_exponent_compare.sv
fp_mantissa_align.sv
fp_normalize.sv
fp_round.sv
fp_add_sub.sv
fp_add_sub_tb.sv

// File: fp_add_macros.svh
`ifndef FP_ADD_MACROS_SVH
`define FP_ADD_MACROS_SVH

////////////////////////////////////////////////////////////////////////////
// Single-precision field widths
////////////////////////////////////////////////////////////////////////////

`define FP_WIDTH       32
`define FP_EXP_WIDTH   8
`define FP_MAN_WIDTH   23

// Carry, hidden one, fraction, then guard, round and sticky
`define FP_WIDE_WIDTH  (`FP_MAN_WIDTH + 5)

// All-ones exponent marks infinity
`define FP_EXP_MAX     255

////////////////////////////////////////////////////////////////////////////
// Pipeline
////////////////////////////////////////////////////////////////////////////

// Cycles from valid_in to valid_out
`define FP_ADD_LATENCY 7

`endif

// File: fp_add_sub.sv
`default_nettype none

`include "fp_add_macros.svh"

module fp_add_sub (
	input  logic             clk,
	input  logic             reset,
	input  logic             valid_in,
	input  fp_pkg::fp_word_t in_a,
	input  fp_pkg::fp_word_t in_b,
	output fp_pkg::fp_word_t out,
	output logic             valid_out
);

	localparam int SIGN_BIT  = `FP_WIDTH - 1;
	localparam int EXP_LSB   = `FP_MAN_WIDTH;
	// Larger exponent waits through align and add
	localparam int EXP_DEPTH = 2;
	// Sign register at S4 through to the S7 output register
	localparam int SIGN_DEPTH = `FP_ADD_LATENCY - 4;

	fp_pkg::fp_word_t     clean_a;
	fp_pkg::fp_word_t     clean_b;
	logic                 cancel;
	logic                 s1_valid;
	fp_pkg::fp_word_t     s1_a;
	fp_pkg::fp_word_t     s1_b;
	fp_pkg::fp_wide_man_t s2_man_a;
	fp_pkg::fp_wide_man_t s2_man_b;
	logic                 s2_sign_a;
	logic                 s2_sign_b;
	logic                 cmp_valid;
	fp_pkg::fp_exp_t      cmp_exp_large;
	fp_pkg::fp_exp_t      cmp_exp_diff;
	logic                 cmp_swap;
	logic                 s3_sign_large;
	logic                 s3_sub;
	logic                 align_valid;
	fp_pkg::fp_wide_man_t align_man_large;
	fp_pkg::fp_wide_man_t align_man_small;
	fp_pkg::fp_wide_man_t man_sum;
	logic                 s4_valid;
	fp_pkg::fp_wide_man_t s4_man_sum;
	logic                 exp_dly_valid;
	fp_pkg::fp_exp_t      exp_dly;
	logic                 sign_dly_valid;
	logic                 sign_dly;
	logic                 norm_valid;
	fp_pkg::fp_wide_man_t norm_man;
	fp_pkg::fp_exp_t      norm_exp;
	logic                 norm_zero;
	logic                 rnd_valid;
	fp_pkg::fp_man_t      rnd_frac;
	fp_pkg::fp_exp_t      rnd_exp;

	// Hidden one only for a nonzero exponent
	function automatic fp_pkg::fp_wide_man_t widen(input fp_pkg::fp_word_t w);
		return {1'b0, |w[SIGN_BIT-1:EXP_LSB], w[EXP_LSB-1:0], 3'b000};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// S1 input cleanup
	////////////////////////////////////////////////////////////////////////////

	assign cancel = (in_a[SIGN_BIT] ^ in_b[SIGN_BIT]) &&
	                (in_a[SIGN_BIT-1:0] == in_b[SIGN_BIT-1:0]);

	// Zero exponent covers negative zero and denormals
	assign clean_a = (cancel || (in_a[SIGN_BIT-1:EXP_LSB] == '0)) ? '0 : in_a;
	assign clean_b = (cancel || (in_b[SIGN_BIT-1:EXP_LSB] == '0)) ? '0 : in_b;

	always_ff @(posedge clk) begin
		if (reset) begin
			s1_valid <= 1'b0;
			s1_a     <= '0;
			s1_b     <= '0;
		end else begin
			s1_valid <= valid_in;
			if (valid_in) begin
				s1_a <= clean_a;
				s1_b <= clean_b;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// S2 exponent compare, operand fields ride alongside
	////////////////////////////////////////////////////////////////////////////

	fp_exponent_compare i_exponent_compare (
		.clk      (clk),
		.reset    (reset),
		.valid_in (s1_valid),
		.exp_a    (s1_a[SIGN_BIT-1:EXP_LSB]),
		.exp_b    (s1_b[SIGN_BIT-1:EXP_LSB]),
		.frac_a   (s1_a[EXP_LSB-1:0]),
		.frac_b   (s1_b[EXP_LSB-1:0]),
		.valid_out(cmp_valid),
		.exp_large(cmp_exp_large),
		.exp_diff (cmp_exp_diff),
		.swap     (cmp_swap)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			s2_man_a  <= '0;
			s2_man_b  <= '0;
			s2_sign_a <= 1'b0;
			s2_sign_b <= 1'b0;
		end else if (s1_valid) begin
			s2_man_a  <= widen(s1_a);
			s2_man_b  <= widen(s1_b);
			s2_sign_a <= s1_a[SIGN_BIT];
			s2_sign_b <= s1_b[SIGN_BIT];
		end
	end

	pipe_delay #(
		.payload_t(fp_pkg::fp_exp_t),
		.DEPTH    (EXP_DEPTH)
	) i_exp_delay (
		.clk      (clk),
		.reset    (reset),
		.valid_in (cmp_valid),
		.data_in  (cmp_exp_large),
		.valid_out(exp_dly_valid),
		.data_out (exp_dly)
	);

	////////////////////////////////////////////////////////////////////////////
	// S3 mantissa align
	////////////////////////////////////////////////////////////////////////////

	fp_mantissa_align i_mantissa_align (
		.clk      (clk),
		.reset    (reset),
		.valid_in (cmp_valid),
		.swap     (cmp_swap),
		.exp_diff (cmp_exp_diff),
		.man_a    (s2_man_a),
		.man_b    (s2_man_b),
		.valid_out(align_valid),
		.man_large(align_man_large),
		.man_small(align_man_small)
	);

	always_ff @(posedge clk) begin
		if (reset) begin
			s3_sign_large <= 1'b0;
			s3_sub        <= 1'b0;
		end else if (cmp_valid) begin
			s3_sign_large <= cmp_swap ? s2_sign_b : s2_sign_a;
			s3_sub        <= s2_sign_a ^ s2_sign_b;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// S4 add or subtract
	////////////////////////////////////////////////////////////////////////////

	// Operands are ordered by magnitude, so the difference is never negative
	assign man_sum = s3_sub ? align_man_large + ~align_man_small + 1'b1
	                        : align_man_large + align_man_small;

	always_ff @(posedge clk) begin
		if (reset) begin
			s4_valid   <= 1'b0;
			s4_man_sum <= '0;
		end else begin
			s4_valid <= align_valid;
			if (align_valid) begin
				s4_man_sum <= man_sum;
			end
		end
	end

	// First register of the chain is the S4 sign
	pipe_delay #(
		.payload_t(logic),
		.DEPTH    (SIGN_DEPTH)
	) i_sign_delay (
		.clk      (clk),
		.reset    (reset),
		.valid_in (align_valid),
		.data_in  (s3_sign_large),
		.valid_out(sign_dly_valid),
		.data_out (sign_dly)
	);

	////////////////////////////////////////////////////////////////////////////
	// S5 normalize, S6 round
	////////////////////////////////////////////////////////////////////////////

	fp_normalize i_normalize (
		.clk      (clk),
		.reset    (reset),
		.valid_in (s4_valid & exp_dly_valid),
		.man_sum  (s4_man_sum),
		.exp_in   (exp_dly),
		.valid_out(norm_valid),
		.man_norm (norm_man),
		.exp_out  (norm_exp),
		.is_zero  (norm_zero)
	);

	fp_round i_round (
		.clk      (clk),
		.reset    (reset),
		.valid_in (norm_valid),
		.man_norm (norm_man),
		.exp_in   (norm_exp),
		.is_zero  (norm_zero),
		.valid_out(rnd_valid),
		.frac_out (rnd_frac),
		.exp_out  (rnd_exp)
	);

	////////////////////////////////////////////////////////////////////////////
	// S7 output packing
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			out       <= '0;
			valid_out <= 1'b0;
		end else begin
			valid_out <= rnd_valid & sign_dly_valid;
			if (rnd_valid & sign_dly_valid) begin
				// Zero results are always positive
				out <= {sign_dly & ~((rnd_exp == '0) && (rnd_frac == '0)), rnd_exp, rnd_frac};
			end
		end
	end

endmodule

`default_nettype wire

// File: fp_add_sub_tb.sv
`default_nettype none

`include "fp_add_macros.svh"

module fp_add_sub_tb;

	localparam int RESET_CYCLES   = 16;
	localparam int STREAM_ITEMS   = 200;
	localparam int MAX_GAP        = 3;
	localparam int DIRECTED_ITEMS = 31;
	localparam int TEST_COUNT     = 6;
	// Every item plus its gaps, a drain per test, and some slack
	localparam int TIMEOUT_CYCLES = RESET_CYCLES + DIRECTED_ITEMS +
	                                STREAM_ITEMS * (MAX_GAP + 1) +
	                                TEST_COUNT * (`FP_ADD_LATENCY + 2) + 100;

	logic             clk;
	logic             reset;
	logic             valid_in;
	fp_pkg::fp_word_t in_a;
	fp_pkg::fp_word_t in_b;
	fp_pkg::fp_word_t sum_out;
	logic             valid_out;

	fp_pkg::fp_word_t expected_q [$];
	int               issue_q [$];
	int               cycle_count;
	int               issue_cycle;
	int               checks;
	int               errors;
	int unsigned      seed_value;

	fp_add_sub i_fp_add_sub (
		.clk      (clk),
		.reset    (reset),
		.valid_in (valid_in),
		.in_a     (in_a),
		.in_b     (in_b),
		.out      (sum_out),
		.valid_out(valid_out)
	);

	always #4 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	// Exact widening into a double with zero exponents flushed
	function automatic real to_real(input fp_pkg::fp_word_t w);
		logic [63:0] d;
		if (w[30:23] == 8'h00) begin
			return 0.0;
		end
		d = {w[31], 11'(int'(w[30:23]) - 127 + 1023), w[22:0], 29'h0};
		return $bitstoreal(d);
	endfunction

	function automatic fp_pkg::fp_word_t expected_sum(input fp_pkg::fp_word_t a,
	                                                  input fp_pkg::fp_word_t b);
		real         s;
		logic [63:0] d;
		int          e;
		logic [24:0] m;
		s = to_real(a) + to_real(b);
		// Exact cancellation and signed zeros all give +0
		if (s == 0.0) begin
			return '0;
		end
		d = $realtobits(s);
		e = int'(d[62:52]) - 1023 + 127;
		if (e <= 0) begin
			return '0;
		end
		m = {2'b01, d[51:29]};
		// Nearest even on the 29 dropped bits
		if (d[28] && ((|d[27:0]) || m[0])) begin
			m = m + 25'd1;
		end
		if (m[24]) begin
			e = e + 1;
		end
		if (e >= `FP_EXP_MAX) begin
			return {d[63], 8'hff, 23'h0};
		end
		return {d[63], 8'(e), m[22:0]};
	endfunction

	function automatic fp_pkg::fp_word_t random_normal();
		return {1'($urandom), 8'($urandom_range(100, 139)), 23'($urandom)};
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Driving and checking
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input fp_pkg::fp_word_t got,
	                          input fp_pkg::fp_word_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic compare_latency(input int got);
		checks++;
		if (got != `FP_ADD_LATENCY) begin
			errors++;
			$display("valid_out came %0d cycles after valid_in instead of %0d",
			         got, `FP_ADD_LATENCY);
		end
	endtask

	task automatic send_pair(input fp_pkg::fp_word_t a, input fp_pkg::fp_word_t b);
		@(negedge clk);
		valid_in = 1'b1;
		in_a     = a;
		in_b     = b;
		expected_q.push_back(expected_sum(a, b));
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		valid_in = 1'b0;
	endtask

	task automatic end_test(input string name, input int err_start);
		idle_cycle();
		while (expected_q.size() != 0) begin
			@(negedge clk);
		end
		if (errors == err_start) begin
			$display("%s: ok", name);
		end else begin
			$display("%s: %0d errors", name, errors - err_start);
		end
	endtask

	// Cycle stamps are taken at the rising edge, before the DUT registers update
	always @(posedge clk) begin
		if (valid_out) begin
			if (issue_q.size() == 0 || expected_q.size() == 0) begin
				errors++;
				$display("valid_out high at cycle %0d with no item in flight", cycle_count);
			end else begin
				issue_cycle = issue_q.pop_front();
				compare_latency(cycle_count - issue_cycle);
				check_word("out", sum_out, expected_q.pop_front());
			end
		end
		if (valid_in && !reset) begin
			issue_q.push_back(cycle_count);
		end
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == TIMEOUT_CYCLES) begin
			$display("run stopped after %0d cycles with results still missing", cycle_count);
			$display("Simulation failed");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_same_sign();
		int err_start;
		err_start = errors;
		send_pair(32'h3f800000, 32'h3f800000);
		send_pair(32'h3fc00000, 32'h3fc00000);
		send_pair(32'h3f800000, 32'h3f000000);
		send_pair(32'h40400000, 32'h3f800000);
		send_pair(32'hbf800000, 32'hbfc00000);
		send_pair(32'hc0400000, 32'hbf000000);
		send_pair(32'h3fa00000, 32'h40490fdb);
		end_test("same_sign", err_start);
	endtask

	task automatic test_opposite_sign();
		int err_start;
		err_start = errors;
		// Near cancellation with a long left shift
		send_pair(32'h3f800001, 32'hbf800000);
		send_pair(32'h3f800000, 32'hbf7fffff);
		send_pair(32'h40000000, 32'hbfc00000);
		// Sign follows the larger magnitude
		send_pair(32'h3f800000, 32'hc0000000);
		send_pair(32'hbf800000, 32'h3f000000);
		end_test("opposite_sign", err_start);
	endtask

	task automatic test_zero_cleanup();
		int err_start;
		err_start = errors;
		send_pair(32'h3fc00000, 32'h00000000);
		send_pair(32'h00000000, 32'h80000000);
		send_pair(32'h80000000, 32'h80000000);
		send_pair(32'h40490fdb, 32'hc0490fdb);
		// Denormals act as zero
		send_pair(32'h00000001, 32'h3f800000);
		send_pair(32'h807fffff, 32'h00400000);
		end_test("zero_cleanup", err_start);
	endtask

	task automatic test_rounding();
		int err_start;
		err_start = errors;
		// Exact ties where an even LSB stays and an odd LSB goes up
		send_pair(32'h3f800000, 32'h33800000);
		send_pair(32'h3f800001, 32'h33800000);
		// Sticky bit above a tie rounds up
		send_pair(32'h3f800000, 32'h33800001);
		// Only sticky survives the alignment
		send_pair(32'h3f800000, 32'h0d800000);
		send_pair(32'h3f800000, 32'hae800000);
		// Rounding carry renormalizes
		send_pair(32'h3fffffff, 32'h33800000);
		send_pair(32'h3fffffff, 32'h33c00000);
		end_test("rounding", err_start);
	endtask

	task automatic test_range_limits();
		int err_start;
		err_start = errors;
		send_pair(32'h7f7fffff, 32'h7f7fffff);
		send_pair(32'hff7fffff, 32'hff000000);
		send_pair(32'h7f7fffff, 32'h73800000);
		send_pair(32'h00800001, 32'h80800000);
		send_pair(32'h00c00000, 32'h80800000);
		send_pair(32'h00800000, 32'h00800000);
		end_test("range_limits", err_start);
	endtask

	task automatic test_streaming();
		int err_start;
		int gap;
		err_start = errors;
		for (int i = 0; i < STREAM_ITEMS; i++) begin
			send_pair(random_normal(), random_normal());
			gap = $urandom_range(0, MAX_GAP);
			repeat (gap) idle_cycle();
		end
		end_test("streaming", err_start);
	endtask

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		valid_in    = 1'b0;
		in_a        = '0;
		in_b        = '0;
		cycle_count = 0;
		checks      = 0;
		errors      = 0;
		seed_value  = $urandom(26908);
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		test_same_sign();
		test_opposite_sign();
		test_zero_cleanup();
		test_rounding();
		test_range_limits();
		test_streaming();

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: fp_exponent_compare.sv
`default_nettype none

module fp_exponent_compare (
	input  logic            clk,
	input  logic            reset,
	input  logic            valid_in,
	input  fp_pkg::fp_exp_t exp_a,
	input  fp_pkg::fp_exp_t exp_b,
	input  fp_pkg::fp_man_t frac_a,
	input  fp_pkg::fp_man_t frac_b,
	output logic            valid_out,
	output fp_pkg::fp_exp_t exp_large,
	output fp_pkg::fp_exp_t exp_diff,
	output logic            swap
);

	logic b_larger;

	// Magnitude order, fraction breaks an exponent tie
	assign b_larger = (exp_b > exp_a) || ((exp_b == exp_a) && (frac_b > frac_a));

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
			exp_large <= '0;
			exp_diff  <= '0;
			swap      <= 1'b0;
		end else begin
			valid_out <= valid_in;
			if (valid_in) begin
				swap <= b_larger;
				if (b_larger) begin
					exp_large <= exp_b;
					exp_diff  <= exp_b - exp_a;
				end else begin
					exp_large <= exp_a;
					exp_diff  <= exp_a - exp_b;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: fp_mantissa_align.sv
`default_nettype none

`include "fp_add_macros.svh"

module fp_mantissa_align (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 valid_in,
	input  logic                 swap,
	input  fp_pkg::fp_exp_t      exp_diff,
	input  fp_pkg::fp_wide_man_t man_a,
	input  fp_pkg::fp_wide_man_t man_b,
	output logic                 valid_out,
	output fp_pkg::fp_wide_man_t man_large,
	output fp_pkg::fp_wide_man_t man_small
);

	// Shifts past this leave nothing but the sticky bit
	localparam int ALIGN_LIMIT = `FP_WIDE_WIDTH - 1;

	fp_pkg::fp_wide_man_t man_lesser;
	fp_pkg::fp_wide_man_t man_shifted;
	fp_pkg::fp_wide_man_t lost_mask;
	logic                 sticky;

	always_comb begin
		man_lesser = swap ? man_a : man_b;
		lost_mask  = '0;
		if (exp_diff >= ALIGN_LIMIT) begin
			man_shifted = '0;
			sticky      = |man_lesser;
		end else begin
			lost_mask   = ({{(`FP_WIDE_WIDTH-1){1'b0}}, 1'b1} << exp_diff) - 1'b1;
			man_shifted = man_lesser >> exp_diff;
			sticky      = |(man_lesser & lost_mask);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
			man_large <= '0;
			man_small <= '0;
		end else begin
			valid_out <= valid_in;
			if (valid_in) begin
				man_large <= swap ? man_b : man_a;
				man_small <= {man_shifted[`FP_WIDE_WIDTH-1:1], man_shifted[0] | sticky};
			end
		end
	end

endmodule

`default_nettype wire

// File: fp_normalize.sv
`default_nettype none

`include "fp_add_macros.svh"

module fp_normalize (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 valid_in,
	input  fp_pkg::fp_wide_man_t man_sum,
	input  fp_pkg::fp_exp_t      exp_in,
	output logic                 valid_out,
	output fp_pkg::fp_wide_man_t man_norm,
	output fp_pkg::fp_exp_t      exp_out,
	output logic                 is_zero
);

	localparam int TOP = `FP_WIDE_WIDTH - 1;

	logic [4:0]           lz;
	fp_pkg::fp_wide_man_t man_next;
	fp_pkg::fp_exp_t      exp_next;
	logic                 zero_next;

	// Leading zeros below the carry bit, 27 for an empty sum
	always_comb begin
		lz = 5'(TOP);
		for (int i = 0; i < TOP; i++) begin
			if (man_sum[i]) begin
				lz = 5'(TOP - 1 - i);
			end
		end
	end

	always_comb begin
		zero_next = 1'b0;
		if (man_sum[TOP]) begin
			// Carry out, one step right and fold the dropped bit into sticky
			man_next = {1'b0, man_sum[TOP:2], man_sum[1] | man_sum[0]};
			exp_next = exp_in + 1'b1;
		end else begin
			man_next  = man_sum << lz;
			exp_next  = exp_in - lz;
			// Cancelled sum, or exponent would land at zero or below
			zero_next = (man_sum == '0) || ({3'b000, lz} >= exp_in);
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
			man_norm  <= '0;
			exp_out   <= '0;
			is_zero   <= 1'b0;
		end else begin
			valid_out <= valid_in;
			if (valid_in) begin
				man_norm <= zero_next ? '0 : man_next;
				exp_out  <= zero_next ? '0 : exp_next;
				is_zero  <= zero_next;
			end
		end
	end

endmodule

`default_nettype wire

// File: fp_pkg.sv
`default_nettype none

`include "fp_add_macros.svh"

package fp_pkg;

	// Packed IEEE single word, sign at the top
	typedef logic [`FP_WIDTH-1:0] fp_word_t;

	// Biased exponent
	typedef logic [`FP_EXP_WIDTH-1:0] fp_exp_t;

	// Stored fraction without the hidden one
	typedef logic [`FP_MAN_WIDTH-1:0] fp_man_t;

	// Working mantissa for align, add, normalize and round
	// Bit 27 carry or sign, bit 26 hidden one, 25..3 fraction,
	// bit 2 guard, bit 1 round, bit 0 sticky
	typedef logic [`FP_WIDE_WIDTH-1:0] fp_wide_man_t;

endpackage

`default_nettype wire

// File: fp_round.sv
`default_nettype none

`include "fp_add_macros.svh"

module fp_round (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 valid_in,
	input  fp_pkg::fp_wide_man_t man_norm,
	input  fp_pkg::fp_exp_t      exp_in,
	input  logic                 is_zero,
	output logic                 valid_out,
	output fp_pkg::fp_man_t      frac_out,
	output fp_pkg::fp_exp_t      exp_out
);

	logic                     round_up;
	logic [`FP_MAN_WIDTH+1:0] man_rnd;
	logic                     carry;
	logic [`FP_EXP_WIDTH:0]   exp_rnd;

	always_comb begin
		// Above half, or exactly half with an odd kept LSB
		round_up = man_norm[2] && (man_norm[1] || man_norm[0] || man_norm[3]);
		man_rnd  = {1'b0, man_norm[`FP_MAN_WIDTH+3:3]} + round_up;
		carry    = man_rnd[`FP_MAN_WIDTH+1];
		exp_rnd  = {1'b0, exp_in} + carry;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out <= 1'b0;
			frac_out  <= '0;
			exp_out   <= '0;
		end else begin
			valid_out <= valid_in;
			if (valid_in) begin
				if (is_zero) begin
					frac_out <= '0;
					exp_out  <= '0;
				end else if (exp_rnd >= `FP_EXP_MAX) begin
					// Saturate to infinity
					frac_out <= '0;
					exp_out  <= fp_pkg::fp_exp_t'(`FP_EXP_MAX);
				end else begin
					frac_out <= carry ? man_rnd[`FP_MAN_WIDTH:1] : man_rnd[`FP_MAN_WIDTH-1:0];
					exp_out  <= exp_rnd[`FP_EXP_WIDTH-1:0];
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: pipe_delay.sv
`default_nettype none

module pipe_delay #(
	parameter type payload_t = logic,
	parameter int  DEPTH     = 2
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     valid_in,
	input  payload_t data_in,
	output logic     valid_out,
	output payload_t data_out
);

	payload_t         data_q [DEPTH];
	logic [DEPTH-1:0] valid_q;

	// Each stage only loads when the stage before it holds a valid item
	always_ff @(posedge clk) begin
		if (reset) begin
			valid_q <= '0;
			data_q  <= '{default: '0};
		end else begin
			valid_q[0] <= valid_in;
			if (valid_in) begin
				data_q[0] <= data_in;
			end
			for (int i = 1; i < DEPTH; i++) begin
				valid_q[i] <= valid_q[i-1];
				if (valid_q[i-1]) begin
					data_q[i] <= data_q[i-1];
				end
			end
		end
	end

	assign valid_out = valid_q[DEPTH-1];
	assign data_out  = data_q[DEPTH-1];

endmodule

`default_nettype wire
